//--- src/arena_pkg.sv
/*
 * Shared types and fixed game rules for the light-cycle core.
 * Every stage and the top level take these by wildcard import.
 */
`default_nettype none

package arena_pkg;

	// cell coordinates and scores
	typedef logic [3:0] coord_t;
	typedef logic [7:0] cell_t;
	typedef logic [1:0] score_t;

	// headings in clockwise order, so a right turn is +1
	typedef enum logic [1:0] {DIR_NORTH, DIR_EAST, DIR_SOUTH, DIR_WEST} dir_t;

	typedef enum logic [1:0] {TURN_NONE, TURN_LEFT, TURN_RIGHT} turn_t;

	typedef enum logic [1:0] {MATCH_IDLE, MATCH_PLAYING, MATCH_WON} match_state_t;

	// arena is square, cells outside the inner 14x14 are walls
	localparam int GRID_DIM = 16;

	localparam score_t WIN_POINTS = 2'd3;

	// start cells, row in the upper nibble
	localparam cell_t BLUE_START = 8'h82;
	localparam cell_t RED_START = 8'h8D;

	localparam dir_t BLUE_START_DIR = DIR_EAST;
	localparam dir_t RED_START_DIR = DIR_WEST;

endpackage

`default_nettype wire

//--- src/head_if.sv
/*
 * New head cells of both cycles, sent once per game step
 * from the motion stage to the collision stage.
 */
`timescale 1ns/1ns
`default_nettype none

interface head_if
	import arena_pkg::*;
();

	// heads are valid while this one-cycle strobe is high
	logic step;
	cell_t blue_head;
	cell_t red_head;

	modport mover (
		output step,
		output blue_head,
		output red_head
	);

	modport reader (
		input step,
		input blue_head,
		input red_head
	);

endinterface

`default_nettype wire

//--- src/cycle_motion.sv
/*
 * First stage. On each game step while playing, applies the turn
 * commands and moves both heads one cell, then strobes the heads out.
 * A round reset puts both cycles back on their start cells.
 */
`timescale 1ns/1ns
`default_nettype none

module cycle_motion
	import arena_pkg::*;
(
	input logic Clk,
	input logic rst,
	input logic step,
	input turn_t blue_turn,
	input turn_t red_turn,
	input logic playing,
	input logic round_reset,
	head_if.mover heads
);

	dir_t blue_dir;
	dir_t red_dir;
	dir_t blue_dir_next;
	dir_t red_dir_next;

	function automatic dir_t rotate(input dir_t d, input turn_t t);
		dir_t r;
		case (t)
			TURN_LEFT: r = dir_t'(d - 2'd1);
			TURN_RIGHT: r = dir_t'(d + 2'd1);
			default: r = d;
		endcase
		return r;
	endfunction

	// wraps at the edges, the collision stage catches the wall first
	function automatic cell_t advance(input cell_t c, input dir_t d);
		coord_t row;
		coord_t col;
		row = c[7:4];
		col = c[3:0];
		case (d)
			DIR_NORTH: row = row - 4'd1;
			DIR_SOUTH: row = row + 4'd1;
			DIR_EAST: col = col + 4'd1;
			default: col = col - 4'd1;
		endcase
		return {row, col};
	endfunction

	assign blue_dir_next = rotate(blue_dir, blue_turn);
	assign red_dir_next = rotate(red_dir, red_turn);

	always_ff @(posedge Clk)
	begin
		if (rst || round_reset)
		begin
			blue_dir <= BLUE_START_DIR;
			red_dir <= RED_START_DIR;
			heads.blue_head <= BLUE_START;
			heads.red_head <= RED_START;
			heads.step <= 1'b0;
		end
		else
		begin
			heads.step <= 1'b0;
			// steps outside a match are dropped
			if (step && playing)
			begin
				blue_dir <= blue_dir_next;
				red_dir <= red_dir_next;
				heads.blue_head <= advance(heads.blue_head, blue_dir_next);
				heads.red_head <= advance(heads.red_head, red_dir_next);
				heads.step <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/trail_collision.sv
/*
 * Second stage. Keeps one occupancy bit per arena cell and, for each
 * strobe of new heads, decides which cycles crashed. The outcome
 * strobe follows every step by one cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module trail_collision
	import arena_pkg::*;
(
	input logic Clk,
	input logic rst,
	head_if.reader heads,
	input logic round_reset,
	output logic outcome,
	output logic blue_crash,
	output logic red_crash
);

	localparam int CELLS = GRID_DIM * GRID_DIM;

	// bit index is the cell value in row-major order
	logic [CELLS-1:0] occupied;

	logic blue_hit;
	logic red_hit;
	logic heads_meet;

	function automatic logic on_border(input cell_t c);
		coord_t row;
		coord_t col;
		coord_t edge_max;
		row = c[7:4];
		col = c[3:0];
		edge_max = coord_t'(GRID_DIM - 1);
		return (row == 4'd0) || (row == edge_max) || (col == 4'd0) || (col == edge_max);
	endfunction

	assign heads_meet = (heads.blue_head == heads.red_head);

	// wall, any trail including its own, or the other head
	assign blue_hit = on_border(heads.blue_head) || occupied[heads.blue_head] || heads_meet;
	assign red_hit = on_border(heads.red_head) || occupied[heads.red_head] || heads_meet;

	// occupancy and strobe
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			occupied <= '0;
			outcome <= 1'b0;
		end
		else if (round_reset)
		begin
			// a new round starts with only the start cells taken
			occupied <= '0;
			occupied[BLUE_START] <= 1'b1;
			occupied[RED_START] <= 1'b1;
			outcome <= 1'b0;
		end
		else
		begin
			outcome <= heads.step;
			if (heads.step)
			begin
				occupied[heads.blue_head] <= 1'b1;
				occupied[heads.red_head] <= 1'b1;
			end
		end
	end

	// crash flags only matter while outcome is high
	always_ff @(posedge Clk)
	begin
		if (heads.step)
		begin
			blue_crash <= blue_hit;
			red_crash <= red_hit;
		end
	end

endmodule

`default_nettype wire

//--- src/match_score.sv
/*
 * Third stage. Credits a point when exactly one cycle crashes, ends the
 * match at three points and holds the winner flag until the next start.
 * Issues the round reset that puts the other stages back to the start.
 */
`timescale 1ns/1ns
`default_nettype none

module match_score
	import arena_pkg::*;
(
	input logic Clk,
	input logic rst,
	input logic start,
	input logic outcome,
	input logic blue_crash,
	input logic red_crash,
	output score_t score_blue,
	output score_t score_red,
	output logic round_over,
	output logic round_reset,
	output logic playing,
	output logic blue_wins,
	output logic red_wins
);

	match_state_t state;

	logic any_crash;
	score_t blue_next;
	score_t red_next;

	assign any_crash = blue_crash || red_crash;
	assign blue_next = score_blue + 2'd1;
	assign red_next = score_red + 2'd1;

	assign playing = (state == MATCH_PLAYING);

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= MATCH_IDLE;
			score_blue <= '0;
			score_red <= '0;
			round_over <= 1'b0;
			round_reset <= 1'b0;
			blue_wins <= 1'b0;
			red_wins <= 1'b0;
		end
		else
		begin
			round_over <= 1'b0;
			round_reset <= 1'b0;
			case (state)
				MATCH_PLAYING:
				begin
					if (outcome && any_crash)
					begin
						round_over <= 1'b1;
						if (red_crash && !blue_crash)
						begin
							score_blue <= blue_next;
							if (blue_next == WIN_POINTS)
							begin
								state <= MATCH_WON;
								blue_wins <= 1'b1;
							end
							else
								round_reset <= 1'b1;
						end
						else if (blue_crash && !red_crash)
						begin
							score_red <= red_next;
							if (red_next == WIN_POINTS)
							begin
								state <= MATCH_WON;
								red_wins <= 1'b1;
							end
							else
								round_reset <= 1'b1;
						end
						else
							// both crashed, a draw
							round_reset <= 1'b1;
					end
				end
				default:
				begin
					// idle or won, wait for a new match
					if (start)
					begin
						state <= MATCH_PLAYING;
						score_blue <= '0;
						score_red <= '0;
						blue_wins <= 1'b0;
						red_wins <= 1'b0;
						round_reset <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/light_cycle_top.sv
/*
 * Game core of the two-player light-cycle game. Steps, start and turn
 * commands come in as clean strobes and levels; heads, scores and the
 * match result go out. Steps must be at least four cycles apart.
 */
`timescale 1ns/1ns
`default_nettype none

module light_cycle_top
	import arena_pkg::*;
(
	input logic Clk,
	input logic rst,
	input logic step,
	input logic start,
	input turn_t blue_turn,
	input turn_t red_turn,
	output cell_t blue_head,
	output cell_t red_head,
	output score_t score_blue,
	output score_t score_red,
	output logic round_over,
	output logic blue_wins,
	output logic red_wins,
	output logic playing
);

	head_if heads ();

	logic outcome;
	logic blue_crash;
	logic red_crash;
	logic round_reset;

	assign blue_head = heads.blue_head;
	assign red_head = heads.red_head;

	cycle_motion u_motion (
		.Clk(Clk),
		.rst(rst),
		.step(step),
		.blue_turn(blue_turn),
		.red_turn(red_turn),
		.playing(playing),
		.round_reset(round_reset),
		.heads(heads.mover)
	);

	trail_collision u_collision (
		.Clk(Clk),
		.rst(rst),
		.heads(heads.reader),
		.round_reset(round_reset),
		.outcome(outcome),
		.blue_crash(blue_crash),
		.red_crash(red_crash)
	);

	match_score u_score (
		.Clk(Clk),
		.rst(rst),
		.start(start),
		.outcome(outcome),
		.blue_crash(blue_crash),
		.red_crash(red_crash),
		.score_blue(score_blue),
		.score_red(score_red),
		.round_over(round_over),
		.round_reset(round_reset),
		.playing(playing),
		.blue_wins(blue_wins),
		.red_wins(red_wins)
	);

endmodule

`default_nettype wire

//--- bench/light_cycle_tb.sv
/*
 * Random-play testbench for the light-cycle core. A model in the bench
 * tracks headings, heads, trails, scores and winners, and each output
 * is compared at the cycle that the step pipeline fixes.
 */
`timescale 1ns/1ns
`default_nettype none

module light_cycle_tb
	import arena_pkg::*;
();

	localparam int NUM_MATCHES = 4;
	localparam int STEP_LIMIT = 600;
	// five cycles per step, a few per start, plus slack
	localparam int STEP_BUDGET = 1 + NUM_MATCHES * (STEP_LIMIT + 2);
	localparam int TIMEOUT_NS = (STEP_BUDGET * 5 + NUM_MATCHES * 4 + 100) * 8;

	logic Clk;
	logic rst;
	logic step;
	logic start;
	turn_t blue_turn;
	turn_t red_turn;
	cell_t blue_head;
	cell_t red_head;
	score_t score_blue;
	score_t score_red;
	logic round_over;
	logic blue_wins;
	logic red_wins;
	logic playing;

	// model state with headings counted clockwise from north
	int m_blue_dir;
	int m_red_dir;
	cell_t m_blue_head;
	cell_t m_red_head;
	logic [GRID_DIM*GRID_DIM-1:0] m_grid;
	int m_score_blue;
	int m_score_red;
	logic m_blue_wins;
	logic m_red_wins;
	logic m_playing;

	logic [31:0] lcg_state;
	int match_idx;
	int step_count;

	light_cycle_top u_dut (
		.Clk(Clk),
		.rst(rst),
		.step(step),
		.start(start),
		.blue_turn(blue_turn),
		.red_turn(red_turn),
		.blue_head(blue_head),
		.red_head(red_head),
		.score_blue(score_blue),
		.score_red(score_red),
		.round_over(round_over),
		.blue_wins(blue_wins),
		.red_wins(red_wins),
		.playing(playing)
	);

	always #4 Clk = ~Clk;

	function automatic logic [31:0] next_lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// one turn in four per player
	function automatic turn_t turn_from(input logic [31:0] s);
		case (s[18:16])
			3'd0: return TURN_LEFT;
			3'd1: return TURN_RIGHT;
			default: return TURN_NONE;
		endcase
	endfunction

	function automatic int next_heading(input int d, input turn_t t);
		if (t == TURN_RIGHT)
			return (d + 1) % 4;
		else if (t == TURN_LEFT)
			return (d + 3) % 4;
		return d;
	endfunction

	// rows grow southward, columns grow eastward
	function automatic cell_t move_cell(input cell_t c, input int d);
		int row;
		int col;
		row = int'(c[7:4]);
		col = int'(c[3:0]);
		case (d)
			0: row = (row + GRID_DIM - 1) % GRID_DIM;
			1: col = (col + 1) % GRID_DIM;
			2: row = (row + 1) % GRID_DIM;
			default: col = (col + GRID_DIM - 1) % GRID_DIM;
		endcase
		return {row[3:0], col[3:0]};
	endfunction

	function automatic logic is_wall(input cell_t c);
		return c[7:4] == 4'h0 || c[7:4] == 4'hF || c[3:0] == 4'h0 || c[3:0] == 4'hF;
	endfunction

	task automatic check_val(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic check_heads();
		check_val("blue_head", int'(blue_head), int'(m_blue_head));
		check_val("red_head", int'(red_head), int'(m_red_head));
	endtask

	task automatic check_match(input logic exp_over);
		check_val("round_over", int'(round_over), int'(exp_over));
		check_val("score_blue", int'(score_blue), m_score_blue);
		check_val("score_red", int'(score_red), m_score_red);
		check_val("blue_wins", int'(blue_wins), int'(m_blue_wins));
		check_val("red_wins", int'(red_wins), int'(m_red_wins));
		check_val("playing", int'(playing), int'(m_playing));
	endtask

	task automatic model_round_reset();
		m_blue_dir = int'(BLUE_START_DIR);
		m_red_dir = int'(RED_START_DIR);
		m_blue_head = BLUE_START;
		m_red_head = RED_START;
		m_grid = '0;
		m_grid[BLUE_START] = 1'b1;
		m_grid[RED_START] = 1'b1;
	endtask

	task automatic do_start();
		@(posedge Clk);
		start <= 1'b1;
		@(posedge Clk);
		start <= 1'b0;
		m_score_blue = 0;
		m_score_red = 0;
		m_blue_wins = 1'b0;
		m_red_wins = 1'b0;
		m_playing = 1'b1;
		@(negedge Clk);
		check_match(1'b0);
		@(posedge Clk);
		model_round_reset();
		@(negedge Clk);
		check_heads();
	endtask

	// one game step with random turns followed through the pipeline
	task automatic do_step();
		turn_t bt;
		turn_t rt;
		logic blue_hit;
		logic red_hit;
		logic restart;
		lcg_state = next_lcg(lcg_state);
		bt = turn_from(lcg_state);
		lcg_state = next_lcg(lcg_state);
		rt = turn_from(lcg_state);
		blue_hit = 1'b0;
		red_hit = 1'b0;
		@(posedge Clk);
		step <= 1'b1;
		blue_turn <= bt;
		red_turn <= rt;
		@(posedge Clk);
		step <= 1'b0;
		blue_turn <= TURN_NONE;
		red_turn <= TURN_NONE;
		if (m_playing)
		begin
			m_blue_dir = next_heading(m_blue_dir, bt);
			m_red_dir = next_heading(m_red_dir, rt);
			m_blue_head = move_cell(m_blue_head, m_blue_dir);
			m_red_head = move_cell(m_red_head, m_red_dir);
			blue_hit = is_wall(m_blue_head) || m_grid[m_blue_head] || m_blue_head == m_red_head;
			red_hit = is_wall(m_red_head) || m_grid[m_red_head] || m_blue_head == m_red_head;
			m_grid[m_blue_head] = 1'b1;
			m_grid[m_red_head] = 1'b1;
		end
		@(negedge Clk);
		check_heads();
		@(posedge Clk);
		@(posedge Clk);
		if (red_hit && !blue_hit)
		begin
			m_score_blue++;
			if (m_score_blue == int'(WIN_POINTS))
			begin
				m_blue_wins = 1'b1;
				m_playing = 1'b0;
			end
		end
		else if (blue_hit && !red_hit)
		begin
			m_score_red++;
			if (m_score_red == int'(WIN_POINTS))
			begin
				m_red_wins = 1'b1;
				m_playing = 1'b0;
			end
		end
		restart = (blue_hit || red_hit) && m_playing;
		@(negedge Clk);
		check_match(blue_hit || red_hit);
		@(posedge Clk);
		if (restart)
			model_round_reset();
		@(negedge Clk);
		check_heads();
		check_val("round_over", int'(round_over), 0);
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the game steps did not finish in the expected time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		Clk = 1'b0;
		rst = 1'b1;
		step = 1'b0;
		start = 1'b0;
		blue_turn = TURN_NONE;
		red_turn = TURN_NONE;
		lcg_state = 32'd56176;
		model_round_reset();
		m_grid = '0;
		m_score_blue = 0;
		m_score_red = 0;
		m_blue_wins = 1'b0;
		m_red_wins = 1'b0;
		m_playing = 1'b0;
		repeat (4) @(posedge Clk);
		rst <= 1'b0;
		@(negedge Clk);
		check_heads();
		check_match(1'b0);
		// no match is running yet so the heads must stay put
		do_step();
		for (match_idx = 0; match_idx < NUM_MATCHES; match_idx++)
		begin
			do_start();
			step_count = 0;
			while (m_playing && step_count < STEP_LIMIT)
			begin
				do_step();
				step_count++;
			end
			if (m_playing)
			begin
				$display("match %0d did not end within %0d steps", match_idx, STEP_LIMIT);
				$display("Testbench failed");
				$fatal(1, "match ran too long");
			end
			// steps after the win move nothing
			do_step();
			do_step();
			$display("match %0d won by %s, %0d to %0d after %0d steps", match_idx,
				m_blue_wins ? "blue" : "red", m_score_blue, m_score_red, step_count);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
src/arena_pkg.sv
src/head_if.sv
src/cycle_motion.sv
src/trail_collision.sv
src/match_score.sv
src/light_cycle_top.sv
bench/light_cycle_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module light_cycle_tb -f sources.f -o light_cycle_sim \
	&& ./obj_dir/light_cycle_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "simulation ok" || { echo "simulation bad"; exit 1; }
